// File: common/pov_consts.svh
`ifndef POV_CONSTS_SVH
`define POV_CONSTS_SVH

// angle steps in one revolution of the rotor
`define POV_ROT_RES 32

// bits to hold an angle index, log2 of the above
`define POV_ANGLE_W 5

// pixels in one half of a radial column
`define POV_ROWS 16

// stable cycles before the sensor level is trusted
`define POV_DB_CYCLES 4

// revolution period counter, saturates when the rotor stalls
`define POV_PERIOD_W 16

// POV_ROT_RES must stay a power of two
// the step length comes from a shift by POV_ANGLE_W, not a divide
// POV_ROWS also sets the shift length of one column: 2 cycles per pixel
// keep POV_DB_CYCLES well below the sensor pulse width

`endif

// File: common/pov_pkg.sv
`include "pov_consts.svh"

package pov_pkg;

    // pattern select, driven from the board switches
    typedef enum logic [1:0] {
        MODE_OFF     = 2'd0, // panel dark
        MODE_SECTORS = 2'd1, // four coloured quarters
        MODE_SPIRAL  = 2'd2, // one white pixel walking outwards
        MODE_RSVD    = 2'd3  // unused, renders dark
    } pov_mode_e;

    // panel driver FSM
    typedef enum logic [2:0] {
        HUB_IDLE,     // waiting for a column
        HUB_SHIFT_LO, // data placed, led_clk low
        HUB_SHIFT_HI, // led_clk high, panel samples
        HUB_BLANK,    // oe high before latching
        HUB_LATCH     // latch pulse, row address updated
    } hub_state_e;

    // current rotor angle
    typedef struct packed {
        logic [`POV_ANGLE_W-1:0] angle;
        logic                    valid; // a period has been measured
        logic                    tick;  // angle just changed
    } theta_t;

    // one radial column, both halves
    // index 0 goes out first, rgb bit 2 is red, bit 0 is blue
    typedef struct packed {
        logic [`POV_ANGLE_W-1:0]     angle;
        logic [`POV_ROWS-1:0][2:0]   top; // upper half, rgb0 pins
        logic [`POV_ROWS-1:0][2:0]   bot; // lower half, rgb1 pins
    } column_t;

endpackage

// File: source/debouncer.sv
`timescale 1ns/1ns
`include "pov_consts.svh"

// ir slot sensor chatters as the edge of the slot passes
// output only follows after a run of identical samples
module debouncer (
    input  logic sysclk,
    input  logic rst_n,
    input  logic dirty, // raw sensor level
    output logic clean  // filtered level
);

    localparam int cnt_w = $clog2(`POV_DB_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`POV_DB_CYCLES - 1);

    logic [cnt_w-1:0] run_cnt; // cycles the input has disagreed with clean
    logic             differs;

    assign differs = dirty ^ clean;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            run_cnt <= '0;
            clean   <= 1'b0; // sensor idle after reset
        end else if (differs) begin
            if (run_cnt == cnt_last) begin
                // run complete, follow the input
                clean   <= dirty;
                run_cnt <= '0;
            end else begin
                run_cnt <= run_cnt + 1'b1;
            end
        end else begin
            run_cnt <= '0; // any agreeing sample restarts the run
        end
    end

endmodule

// File: source/detect_to_theta.sv
`timescale 1ns/1ns
`include "pov_consts.svh"

// one trip per revolution from the ir sensor
// measures the period and walks the angle through the turn
module detect_to_theta
    import pov_pkg::*;
(
    input  logic   sysclk,
    input  logic   rst_n,
    input  logic   ir_clean, // debounced sensor
    output theta_t theta
);

    localparam logic [`POV_ANGLE_W-1:0] last_angle = `POV_ANGLE_W'(`POV_ROT_RES - 1);

    logic                     ir_prev;   // for edge detect
    logic                     trip;      // rising edge of ir_clean
    logic                     seen_trip; // first trip done, period not yet valid
    logic [`POV_PERIOD_W-1:0] cyc_cnt;   // cycles since the last trip
    logic [`POV_PERIOD_W-1:0] period;    // last full revolution
    logic [`POV_PERIOD_W-1:0] step_len;  // cycles per angle step
    logic [`POV_PERIOD_W-1:0] step_cnt;
    logic [`POV_PERIOD_W-1:0] step_next;

    assign trip      = ir_clean & ~ir_prev;
    assign step_len  = period >> `POV_ANGLE_W; // period / POV_ROT_RES
    assign step_next = step_cnt + 1'b1;

    // period measurement
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            ir_prev   <= 1'b0;
            cyc_cnt   <= '0;
            seen_trip <= 1'b0;
        end else begin
            ir_prev <= ir_clean;
            if (trip) begin
                cyc_cnt   <= `POV_PERIOD_W'(1); // trip cycle itself counts
                seen_trip <= 1'b1;
            end else if (cyc_cnt != '1) begin
                cyc_cnt <= cyc_cnt + 1'b1; // saturate on a stalled rotor
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (trip)
            period <= cyc_cnt;
    end

    // angle stepping
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            theta    <= '0;
            step_cnt <= '0;
        end else begin
            theta.tick <= 1'b0;
            if (trip) begin
                // restart the turn at angle 0
                theta.angle <= '0;
                theta.tick  <= 1'b1;
                theta.valid <= seen_trip; // second trip gives a real period
                step_cnt    <= '0;
            end else if (theta.valid && theta.angle != last_angle) begin
                if (step_next >= step_len) begin // also covers step_len of 0
                    theta.angle <= theta.angle + 1'b1;
                    theta.tick  <= 1'b1;
                    step_cnt    <= '0;
                end else begin
                    step_cnt <= step_next;
                end
            end
            // hold at the last angle until the next trip
        end
    end

    // before a period is known only a trip may produce a tick
    assert property (@(posedge sysclk) disable iff (!rst_n)
        (theta.tick && !theta.valid) |-> $past(trip));

endmodule

// File: frame_manager/frame_manager.sv
`timescale 1ns/1ns
`include "pov_consts.svh"

// builds the column for each new angle from the selected pattern
// newest column wins, a pending one is overwritten on the next tick
module frame_manager
    import pov_pkg::*;
(
    input  logic      sysclk,
    input  logic      rst_n,
    input  pov_mode_e mode,
    input  theta_t    theta,
    output column_t   col,
    output logic      col_valid,
    input  logic      col_ready
);

    localparam int row_w = $clog2(`POV_ROWS);

    column_t          render;     // column for the current angle
    logic [2:0]       sector_rgb; // colour of the current quarter
    logic [row_w-1:0] spiral_row; // angle mod POV_ROWS
    logic             load;       // new angle worth drawing

    assign load       = theta.tick & theta.valid;
    assign spiral_row = theta.angle[row_w-1:0];

    // quarter colour from the top two angle bits
    always_comb begin
        case (theta.angle[`POV_ANGLE_W-1 -: 2])
            2'd0:    sector_rgb = 3'b100; // red
            2'd1:    sector_rgb = 3'b010; // green
            2'd2:    sector_rgb = 3'b001; // blue
            default: sector_rgb = 3'b111; // white
        endcase
    end

    always_comb begin
        render       = '0;
        render.angle = theta.angle;
        for (int r = 0; r < `POV_ROWS; r++) begin
            case (mode)
                MODE_SECTORS: begin
                    render.top[r] = sector_rgb; // whole column one colour
                    render.bot[r] = sector_rgb;
                end
                MODE_SPIRAL: begin
                    // top walks outwards, bottom walks back in
                    if (r == spiral_row)
                        render.top[r] = 3'b111;
                    if (`POV_ROWS - 1 - r == spiral_row)
                        render.bot[r] = 3'b111;
                end
                default: begin
                    render.top[r] = 3'b000; // off and reserved stay dark
                    render.bot[r] = 3'b000;
                end
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (load)
            col <= render;
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            col_valid <= 1'b0;
        else if (load)
            col_valid <= 1'b1; // also replaces an unaccepted column
        else if (col_ready)
            col_valid <= 1'b0; // taken by the panel driver
    end

    // a waiting column only changes when a newer angle replaces it
    assert property (@(posedge sysclk) disable iff (!rst_n)
        (col_valid && !col_ready && !load) |=> $stable(col));

endmodule

// File: hub75/hub75_output.sv
`timescale 1ns/1ns
`include "pov_consts.svh"

// shifts one column into the panel, then blanks, latches and shows it
// 2 cycles per pixel, then blank, then latch
module hub75_output
    import pov_pkg::*;
(
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  column_t                 col,
    input  logic                    col_valid,
    output logic                    col_ready,
    output logic [`POV_ANGLE_W-1:0] hub75_addr,
    output logic [2:0]              rgb0,       // upper half data
    output logic [2:0]              rgb1,       // lower half data
    output logic                    latch,
    output logic                    oe,         // high blanks the panel
    output logic                    led_clk
);

    localparam int row_w = $clog2(`POV_ROWS);
    localparam logic [row_w-1:0] last_pix = row_w'(`POV_ROWS - 1);

    hub_state_e       state;
    column_t          col_q;    // column being shifted
    logic [row_w-1:0] pix;      // pixel on the pins
    logic [row_w-1:0] pix_next;
    logic             accept;
    logic             advance;  // move to the next pixel

    assign col_ready = (state == HUB_IDLE);
    assign accept    = col_valid & col_ready;
    assign pix_next  = pix + 1'b1;
    assign advance   = (state == HUB_SHIFT_HI) && (pix != last_pix);

    // control FSM
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state      <= HUB_IDLE;
            pix        <= '0;
            led_clk    <= 1'b0;
            latch      <= 1'b0;
            oe         <= 1'b1; // dark until the first column is latched
            hub75_addr <= '0;
        end else begin
            case (state)
                HUB_IDLE: begin
                    if (accept) begin
                        state <= HUB_SHIFT_LO;
                        pix   <= '0;
                    end
                end
                HUB_SHIFT_LO: begin
                    state   <= HUB_SHIFT_HI;
                    led_clk <= 1'b1; // panel samples on this edge
                end
                HUB_SHIFT_HI: begin
                    led_clk <= 1'b0;
                    if (pix == last_pix) begin
                        state <= HUB_BLANK;
                        oe    <= 1'b1;
                    end else begin
                        state <= HUB_SHIFT_LO;
                        pix   <= pix_next;
                    end
                end
                HUB_BLANK: begin
                    state      <= HUB_LATCH;
                    latch      <= 1'b1;
                    hub75_addr <= col_q.angle; // address follows the latched column
                end
                HUB_LATCH: begin
                    state <= HUB_IDLE;
                    latch <= 1'b0;
                    oe    <= 1'b0; // show the new column
                end
                default: state <= HUB_IDLE;
            endcase
        end
    end

    // data path
    always_ff @(posedge sysclk) begin
        if (accept) begin
            col_q <= col;
            rgb0  <= col.top[0]; // first pixel ready for the first low phase
            rgb1  <= col.bot[0];
        end else if (advance) begin
            rgb0 <= col_q.top[pix_next];
            rgb1 <= col_q.bot[pix_next];
        end
    end

    // panel must already be blank the cycle before a latch and during it
    assert property (@(posedge sysclk) disable iff (!rst_n)
        latch |-> (oe && $past(oe)));

endmodule

// File: source/pov_display_top.sv
`timescale 1ns/1ns
`include "pov_consts.svh"

// spinning hub75 panel
// sensor -> debounce -> angle -> column render -> panel shifter
module pov_display_top
    import pov_pkg::*;
(
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    ir_tripped, // slot sensor, one pulse per turn
    input  pov_mode_e               mode,       // pattern select
    output logic                    led0,       // sensor state for alignment
    output logic [`POV_ANGLE_W-1:0] hub75_addr,
    output logic [2:0]              rgb0,
    output logic [2:0]              rgb1,
    output logic                    latch,
    output logic                    oe,
    output logic                    led_clk
);

    logic    ir_clean;
    theta_t  theta;
    column_t col;
    logic    col_valid;
    logic    col_ready;

    assign led0 = ir_clean; // lights while the slot is in front of the sensor

    debouncer ir_db (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .dirty  (ir_tripped),
        .clean  (ir_clean)
    );

    detect_to_theta dt (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .ir_clean (ir_clean),
        .theta    (theta)
    );

    frame_manager fm (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .mode      (mode),
        .theta     (theta),
        .col       (col),
        .col_valid (col_valid),
        .col_ready (col_ready)
    );

    hub75_output hub75 (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .col        (col),
        .col_valid  (col_valid),
        .col_ready  (col_ready),
        .hub75_addr (hub75_addr),
        .rgb0       (rgb0),
        .rgb1       (rgb1),
        .latch      (latch),
        .oe         (oe),
        .led_clk    (led_clk)
    );

endmodule

// File: tests/tb_pov_display.sv
`timescale 1ns/1ns
`include "pov_consts.svh"

// directed tests for the pov globe driver
// a monitor on the panel pins rebuilds every latched column
module tb_pov_display
    import pov_pkg::*;
();

    localparam int trip_period = 2048; // step length of 64 cycles
    localparam int trip_count  = 6;    // revolutions driven over all tests
    localparam int extra_cyc   = 300;  // reset, idle wait, debounce
    localparam int cyc_limit   = (trip_count * trip_period + extra_cyc) * 3 / 2;

    logic                    sysclk;
    logic                    rst_n;
    logic                    ir_tripped;
    pov_mode_e               mode;
    logic                    led0;
    logic [`POV_ANGLE_W-1:0] hub75_addr;
    logic [2:0]              rgb0;
    logic [2:0]              rgb1;
    logic                    latch;
    logic                    oe;
    logic                    led_clk;

    column_t latched[$];             // columns seen on the pins, oldest first
    column_t rev_cols[`POV_ROT_RES]; // first measured revolution
    column_t shift_col;              // column being rebuilt
    int      pix_cnt;
    logic    led_clk_q;
    int      cycles = 0;
    int      errors;
    int      errs_before;
    int      tests_run;
    int      tests_failed;

    pov_display_top dut (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .ir_tripped (ir_tripped),
        .mode       (mode),
        .led0       (led0),
        .hub75_addr (hub75_addr),
        .rgb0       (rgb0),
        .rgb1       (rgb1),
        .latch      (latch),
        .oe         (oe),
        .led_clk    (led_clk)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk; // 4 ns period
    end

    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= cyc_limit) begin
            $display("timeout: run still going after %0d cycles", cyc_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // panel side, looked at mid-cycle so pins are settled
    always @(negedge sysclk) begin
        if (!rst_n) begin
            pix_cnt   = 0;
            led_clk_q = 1'b0;
        end else begin
            if (led_clk && !led_clk_q) begin // rising led_clk, panel takes a pixel
                if (pix_cnt < `POV_ROWS) begin
                    shift_col.top[pix_cnt] = rgb0;
                    shift_col.bot[pix_cnt] = rgb1;
                end
                pix_cnt++;
            end
            led_clk_q = led_clk;
            if (latch) begin
                if (pix_cnt != `POV_ROWS) begin
                    errors++;
                    $display("column latched after %0d pixels, not %0d", pix_cnt, `POV_ROWS);
                end
                shift_col.angle = hub75_addr; // row address names the column
                latched.push_back(shift_col);
                pix_cnt = 0;
            end
        end
    end

    task automatic step(input int n);
        repeat (n) @(posedge sysclk);
        #1; // inputs move just after the edge
    endtask

    // one revolution: slot in front of the sensor for 8 cycles
    task automatic trip(input int period);
        ir_tripped = 1'b1;
        step(8);
        ir_tripped = 1'b0;
        step(period - 8);
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic check_angle(input string what, input logic [`POV_ANGLE_W-1:0] got,
                               input logic [`POV_ANGLE_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic check_column(input string what, input column_t got, input column_t exp);
        if (got !== exp) begin
            errors++;
            if (got.angle !== exp.angle)
                $display("** Error %s.angle: got %h, expected %h", what, got.angle, exp.angle);
            if (got.top !== exp.top)
                $display("** Error %s.top: got %h, expected %h", what, got.top, exp.top);
            if (got.bot !== exp.bot)
                $display("** Error %s.bot: got %h, expected %h", what, got.bot, exp.bot);
        end
    endtask

    // reference picture for one angle
    function automatic column_t expected_column(input pov_mode_e pattern,
                                                input logic [`POV_ANGLE_W-1:0] angle);
        column_t    c;
        logic [2:0] colour;
        int         r;
        c       = '0;
        c.angle = angle;
        case (angle[4:3]) // quarter of the turn
            2'd0:    colour = 3'b100;
            2'd1:    colour = 3'b010;
            2'd2:    colour = 3'b001;
            default: colour = 3'b111;
        endcase
        for (r = 0; r < `POV_ROWS; r++) begin
            if (pattern == MODE_SECTORS) begin
                c.top[r] = colour;
                c.bot[r] = colour;
            end else if (pattern == MODE_SPIRAL) begin
                c.top[r] = (r == angle % `POV_ROWS) ? 3'b111 : 3'b000;
                c.bot[r] = (`POV_ROWS - 1 - r == angle % `POV_ROWS) ? 3'b111 : 3'b000;
            end
        end
        return c; // off and reserved stay black
    endfunction

    // one full revolution, angles 0 up to the last in order
    task automatic check_sequence();
        int i;
        if (latched.size() != `POV_ROT_RES) begin
            errors++;
            $display("saw %0d columns in a revolution instead of %0d",
                     latched.size(), `POV_ROT_RES);
        end
        for (i = 0; i < latched.size() && i < `POV_ROT_RES; i++)
            check_angle($sformatf("col[%0d].angle", i), latched[i].angle, `POV_ANGLE_W'(i));
    endtask

    task automatic check_patterns(input pov_mode_e pattern);
        int i;
        for (i = 0; i < latched.size(); i++)
            check_column($sformatf("col[%0d]", i), latched[i],
                         expected_column(pattern, latched[i].angle));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
        end
        errs_before = errors;
    endtask

    task automatic test_reset_state();
        check_bit("oe", oe, 1'b1);
        check_bit("latch", latch, 1'b0);
        check_bit("led_clk", led_clk, 1'b0);
        check_bit("led0", led0, 1'b0);
        step(200); // no rotor, nothing to show
        if (latched.size() != 0) begin
            errors++;
            $display("%0d columns latched without any trip", latched.size());
        end
        end_test("reset state");
    endtask

    task automatic test_debounce();
        int n;
        ir_tripped = 1'b1; // short glitch
        step(2);
        ir_tripped = 1'b0;
        for (n = 0; n < 8; n++) begin
            step(1);
            check_bit("led0", led0, 1'b0);
        end
        ir_tripped = 1'b1;
        n = 0;
        while (!led0 && n < `POV_DB_CYCLES + 2) begin
            step(1);
            n++;
        end
        if (!led0) begin
            errors++;
            $display("led0 did not rise within %0d cycles of a held trip", `POV_DB_CYCLES + 2);
        end
        ir_tripped = 1'b0;
        n = 0;
        while (led0 && n < `POV_DB_CYCLES + 2) begin
            step(1);
            n++;
        end
        if (led0) begin
            errors++;
            $display("led0 did not fall within %0d cycles of release", `POV_DB_CYCLES + 2);
        end
        step(10);
        end_test("debounce");
    endtask

    task automatic test_angle_sequence();
        int i;
        mode = MODE_SECTORS;
        trip(trip_period); // establishes the period
        latched.delete();
        trip(trip_period);
        check_sequence();
        for (i = 0; i < `POV_ROT_RES; i++)
            rev_cols[i] = (i < latched.size()) ? latched[i] : column_t'('0);
        latched.delete();
        trip(trip_period); // restart from angle 0
        check_sequence();
        end_test("angle sequence");
    endtask

    task automatic test_sector_pattern();
        int i;
        for (i = 0; i < `POV_ROT_RES; i++)
            check_column($sformatf("rev_col[%0d]", i), rev_cols[i],
                         expected_column(MODE_SECTORS, rev_cols[i].angle));
        check_patterns(MODE_SECTORS);
        end_test("sector pattern");
    endtask

    task automatic test_spiral_pattern();
        mode = MODE_SPIRAL;
        latched.delete();
        trip(trip_period);
        check_sequence(); // passes 15 to 16 on the way
        check_patterns(MODE_SPIRAL);
        end_test("spiral pattern");
    endtask

    task automatic test_dark_modes();
        mode = MODE_OFF;
        latched.delete();
        trip(trip_period);
        check_sequence();
        check_patterns(MODE_OFF);
        mode = MODE_RSVD;
        latched.delete();
        trip(trip_period);
        check_sequence();
        check_patterns(MODE_RSVD);
        end_test("dark modes");
    endtask

    initial begin
        rst_n        = 1'b0;
        ir_tripped   = 1'b0;
        mode         = MODE_OFF;
        errors       = 0;
        errs_before  = 0;
        tests_run    = 0;
        tests_failed = 0;
        step(3); // reset for 3 cycles
        rst_n = 1'b1;
        test_reset_state();
        test_debounce();
        test_angle_sequence();
        test_sector_pattern();
        test_spiral_pattern();
        test_dark_modes();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+common
common/pov_pkg.sv
source/debouncer.sv
source/detect_to_theta.sv
frame_manager/frame_manager.sv
hub75/hub75_output.sv
source/pov_display_top.sv
tests/tb_pov_display.sv

// File: Bender.yml
package:
  name: pov_display

export_include_dirs:
  - common

sources:
  - common/pov_pkg.sv
  - source/debouncer.sv
  - source/detect_to_theta.sv
  - frame_manager/frame_manager.sv
  - hub75/hub75_output.sv
  - source/pov_display_top.sv
  - target: test
    files:
      - tests/tb_pov_display.sv
